// ==== all.f ====
src/core_pkg.sv
src/rf_read_if.sv
src/pipe_reg.sv
src/decoder.sv
src/regfile.sv
src/alu.sv
src/pipe_ctrl.sv
src/core_slice_top.sv
dv/core_slice_assertions.sv
dv/core_slice_tb.sv

// ==== dv/core_slice_assertions.sv ====
module core_slice_assertions (
    input logic                clk,
    input logic                rst_n_i,
    input logic                hold_i,
    input logic                instr_ready_i,
    input logic                wb_valid_i,
    input core_pkg::xlen_t     wb_pc_i,
    input core_pkg::reg_addr_t wb_rd_i,
    input logic                wb_we_i,
    input core_pkg::xlen_t     wb_data_i
);

    int violations = 0;

    // a held result sits still on the port.
    wb_stable_on_hold: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        hold_i |=> $stable({wb_valid_i, wb_pc_i, wb_rd_i, wb_we_i, wb_data_i})
    ) else begin
        $error("wb outputs changed while hold_i was high");
        violations++;
    end

    no_intake_on_hold: assert property (
        @(posedge clk) disable iff (!rst_n_i) hold_i |-> !instr_ready_i
    ) else begin
        $error("instr_ready_o was high while hold_i was high");
        violations++;
    end

    no_result_after_reset: assert property (
        @(posedge clk) $rose(rst_n_i) |-> !wb_valid_i
    ) else begin
        $error("wb_valid_o was high in the first cycle after reset");
        violations++;
    end

endmodule

// ==== dv/core_slice_tb.sv ====
module core_slice_tb;

    localparam int NUM_VEC    = 27;
    localparam int VEC_WORDS  = 6; // hold, pc, instr, rd, we, data.
    localparam int MAX_CYCLES = 20 * NUM_VEC + 200;

    logic                clk;
    logic                rst_n_i;
    logic                instr_valid_i;
    logic [31:0]         instr_i;
    core_pkg::xlen_t     pc_i;
    logic                instr_ready_o;
    logic                hold_i;
    logic                wb_valid_o;
    core_pkg::xlen_t     wb_pc_o;
    core_pkg::reg_addr_t wb_rd_o;
    logic                wb_we_o;
    core_pkg::xlen_t     wb_data_o;

    logic [31:0] vec_mem [NUM_VEC*VEC_WORDS];
    int          res_count = 0;
    int          cycles    = 0;
    int          seed      = 26689;

    core_slice_top dut0 (.*);

    bind core_slice_top core_slice_assertions u_assertions (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .hold_i        (hold_i),
        .instr_ready_i (instr_ready_o),
        .wb_valid_i    (wb_valid_o),
        .wb_pc_i       (wb_pc_o),
        .wb_rd_i       (wb_rd_o),
        .wb_we_i       (wb_we_o),
        .wb_data_i     (wb_data_o)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_pc(input core_pkg::xlen_t got, input core_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: pc got %h, expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_rd(input core_pkg::reg_addr_t got_rd, input logic got_we,
                            input core_pkg::reg_addr_t exp_rd, input logic exp_we);
        if (got_rd !== exp_rd || got_we !== exp_we) begin
            $display("Mismatch at %0t: rd/we got %0d/%b, expected %0d/%b",
                     $time, got_rd, got_we, exp_rd, exp_we);
            abort_run();
        end
    endtask

    task automatic check_data(input core_pkg::xlen_t got, input core_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: data got %h, expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    // idle for gap cycles, then offer one vector until the intake takes it.
    task automatic send_instr(input int idx, input int gap);
        logic [3:0] hold_bits;
        int         k;
        logic       taken;
        hold_bits = vec_mem[idx*VEC_WORDS][3:0];
        k         = 0;
        taken     = 1'b0;
        repeat (gap) begin
            @(negedge clk);
            instr_valid_i = 1'b0;
            hold_i        = 1'b0;
        end
        while (!taken) begin
            @(negedge clk);
            instr_valid_i = 1'b1;
            pc_i          = vec_mem[idx*VEC_WORDS+1];
            instr_i       = vec_mem[idx*VEC_WORDS+2];
            hold_i        = (k < 4) ? hold_bits[k] : 1'b0; // one pattern bit per cycle.
            @(posedge clk);
            taken = instr_ready_o;
            k++;
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        hold_i        = 1'b0;
        $readmemh("dv/core_slice_vectors.txt", vec_mem);
        repeat (10) @(negedge clk);
        rst_n_i = 1'b1;
        for (int i = 0; i < NUM_VEC; i++) begin
            send_instr(i, $unsigned($random(seed)) % 3);
        end
        @(negedge clk);
        instr_valid_i = 1'b0;
        hold_i        = 1'b0;
        wait (res_count == NUM_VEC);
        repeat (10) @(posedge clk); // room for a stray extra result.
        if (dut0.u_assertions.violations == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run();
        end
    end

    // results leave in program order, one per vector.
    always @(posedge clk) begin : collect_results
        int base;
        base = res_count * VEC_WORDS;
        if (rst_n_i && wb_valid_o && !hold_i) begin
            if (res_count >= NUM_VEC) begin
                $display("Got an extra result at pc %h after the last instruction.", wb_pc_o);
                abort_run();
            end else begin
                check_pc(wb_pc_o, vec_mem[base+1]);
                check_rd(wb_rd_o, wb_we_o, vec_mem[base+3][4:0], vec_mem[base+4][0]);
                if (vec_mem[base+4][0]) begin
                    check_data(wb_data_o, vec_mem[base+5]);
                end
                res_count <= res_count + 1;
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: results still missing after %0d cycles.", MAX_CYCLES);
            abort_run();
        end else if (dut0.u_assertions.violations != 0) begin
            $display("A bound assertion on the DUT ports failed.");
            abort_run();
        end
    end

endmodule

// ==== dv/core_slice_vectors.txt ====
// hold_nibble pc instr exp_rd exp_we exp_data, one instruction per line.
// hold bit k drives hold_i in the k-th cycle an instruction is offered.
0 00000000 00500093 01 1 00000005
1 00000004 FFD00113 02 1 FFFFFFFD
2 00000008 002081B3 03 1 00000002
0 0000000C 40208233 04 1 00000008
3 00000010 003092B3 05 1 00000014
0 00000014 00112333 06 1 00000001
5 00000018 001133B3 07 1 00000000
0 0000001C 0020C433 08 1 FFFFFFF8
F 00000020 003154B3 09 1 3FFFFFFF
0 00000024 40315533 0A 1 FFFFFFFF
0 00000028 0030E5B3 0B 1 00000007
7 0000002C 0040F633 0C 1 00000000
0 00000030 00309693 0D 1 00000028
1 00000034 FFE12713 0E 1 00000001
0 00000038 FFF0B793 0F 1 00000001
0 0000003C 0F014813 10 1 FFFFFF0D
9 00000040 01C15893 11 1 0000000F
0 00000044 40115913 12 1 FFFFFFFE
3 00000048 7F00E993 13 1 000007F5
0 0000004C 0FF17A13 14 1 000000FD
0 00000050 12345AB7 15 1 12345000
2 00000054 678A8A93 15 1 12345678
0 00000058 00708013 00 1 0000000C
1 0000005C 00000B33 16 1 00000000
0 00000060 0000028B 05 0 00000000
6 00000064 00028B93 17 1 00000014
0 00000068 004A8C33 18 1 12345680

// ==== src/alu.sv ====
module alu (
    input  core_pkg::id_ex_t entry_i,
    output core_pkg::ex_wb_t result_o
);

    core_pkg::xlen_t a;
    core_pkg::xlen_t b;
    logic [4:0]      shamt;
    core_pkg::xlen_t res;

    assign a     = entry_i.op1;
    assign b     = entry_i.op2;
    assign shamt = b[4:0];

    always_comb begin
        case (entry_i.alu_op)
            core_pkg::ADD:    res = a + b;
            core_pkg::SUB:    res = a - b;
            core_pkg::SLL:    res = a << shamt;
            core_pkg::SLT: begin
                res = {31'b0, $signed(a) < $signed(b)};
            end
            core_pkg::SLTU:   res = {31'b0, a < b};
            core_pkg::XOR:    res = a ^ b;
            core_pkg::SRL:    res = a >> shamt;
            core_pkg::SRA:    res = $unsigned($signed(a) >>> shamt);
            core_pkg::OR:     res = a | b;
            core_pkg::AND:    res = a & b;
            core_pkg::PASS_B: res = b; // lui.
            default:          res = '0;
        endcase
    end

    always_comb begin
        result_o.valid  = entry_i.valid;
        result_o.pc     = entry_i.pc;
        result_o.rd     = entry_i.rd;
        result_o.rd_we  = entry_i.rd_we;
        result_o.result = res;
    end

endmodule

// ==== src/core_pkg.sv ====
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int STALL_W    = 5;

    // one bit per pipeline boundary, intake first.
    localparam int STALL_ACCEPT = 0;
    localparam int STALL_IF_ID  = 1;
    localparam int STALL_ID_EX  = 2;
    localparam int STALL_EX_WB  = 3;
    localparam int STALL_SINK   = 4;

    // rv32i major opcodes handled by the slice.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [STALL_W-1:0]    stall_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B
    } alu_op_e;

    typedef struct packed {
        logic  valid;
        xlen_t pc;
        xlen_t instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        xlen_t     op1;
        xlen_t     op2;
        alu_op_e   alu_op;
        reg_addr_t rd;
        logic      rd_we;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        reg_addr_t rd;
        logic      rd_we;
        xlen_t     result;
    } ex_wb_t;

endpackage

// ==== src/core_slice_top.sv ====
module core_slice_top (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                instr_valid_i,
    input  logic [31:0]         instr_i,
    input  core_pkg::xlen_t     pc_i,
    output logic                instr_ready_o,
    input  logic                hold_i,
    output logic                wb_valid_o,
    output core_pkg::xlen_t     wb_pc_o,
    output core_pkg::reg_addr_t wb_rd_o,
    output logic                wb_we_o,
    output core_pkg::xlen_t     wb_data_o
);

    core_pkg::stall_t    stall;
    core_pkg::if_id_t    if_id_d;
    core_pkg::if_id_t    if_id_q;
    core_pkg::id_ex_t    id_ex_d;
    core_pkg::id_ex_t    id_ex_q;
    core_pkg::ex_wb_t    ex_wb_d;
    core_pkg::ex_wb_t    ex_wb_q;
    core_pkg::reg_addr_t rs1_addr;
    core_pkg::reg_addr_t rs2_addr;
    logic                rs1_used;
    logic                rs2_used;
    logic                rf_we;

    rf_read_if rf_rd ();

    assign instr_ready_o = !stall[core_pkg::STALL_ACCEPT];

    // idle cycles load an all-zero entry.
    always_comb begin
        if_id_d = '0;
        if (instr_valid_i) begin
            if_id_d.valid = 1'b1;
            if_id_d.pc    = pc_i;
            if_id_d.instr = instr_i;
        end
    end

    pipe_reg #(.payload_t(core_pkg::if_id_t), .STAGE(core_pkg::STALL_IF_ID)) u_if_id (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stall_i (stall),
        .d_i     (if_id_d),
        .q_o     (if_id_q)
    );

    decoder u_decoder (
        .entry_i    (if_id_q),
        .rf         (rf_rd),
        .dec_o      (id_ex_d),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_used_o (rs1_used),
        .rs2_used_o (rs2_used)
    );

    pipe_reg #(.payload_t(core_pkg::id_ex_t), .STAGE(core_pkg::STALL_ID_EX)) u_id_ex (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stall_i (stall),
        .d_i     (id_ex_d),
        .q_o     (id_ex_q)
    );

    alu u_alu (
        .entry_i  (id_ex_q),
        .result_o (ex_wb_d)
    );

    pipe_reg #(.payload_t(core_pkg::ex_wb_t), .STAGE(core_pkg::STALL_EX_WB)) u_ex_wb (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stall_i (stall),
        .d_i     (ex_wb_d),
        .q_o     (ex_wb_q)
    );

    // written back as the result leaves the port.
    assign rf_we = ex_wb_q.valid && ex_wb_q.rd_we && !hold_i;

    regfile u_regfile (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .rd      (rf_rd),
        .we_i    (rf_we),
        .waddr_i (ex_wb_q.rd),
        .wdata_i (ex_wb_q.result)
    );

    pipe_ctrl u_pipe_ctrl (
        .id_entry_i (if_id_q),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_used_i (rs1_used),
        .rs2_used_i (rs2_used),
        .ex_entry_i (id_ex_q),
        .hold_i     (hold_i),
        .stall_o    (stall)
    );

    assign wb_valid_o = ex_wb_q.valid;
    assign wb_pc_o    = ex_wb_q.pc;
    assign wb_rd_o    = ex_wb_q.rd;
    assign wb_we_o    = ex_wb_q.rd_we;
    assign wb_data_o  = ex_wb_q.result;

endmodule

// ==== src/decoder.sv ====
module decoder (
    input  core_pkg::if_id_t    entry_i,
    rf_read_if.dec              rf,
    output core_pkg::id_ex_t    dec_o,
    output core_pkg::reg_addr_t rs1_addr_o,
    output core_pkg::reg_addr_t rs2_addr_o,
    output logic                rs1_used_o,
    output logic                rs2_used_o
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic                alt_bit;
    core_pkg::reg_addr_t rd;
    core_pkg::xlen_t     imm_i;
    core_pkg::xlen_t     imm_u;
    core_pkg::alu_op_e   alu_sel;
    logic                is_op;

    assign opcode  = entry_i.instr[6:0];
    assign rd      = entry_i.instr[11:7];
    assign funct3  = entry_i.instr[14:12];
    assign alt_bit = entry_i.instr[30]; // funct7[5].
    assign imm_i   = {{20{entry_i.instr[31]}}, entry_i.instr[31:20]};
    assign imm_u   = {entry_i.instr[31:12], 12'b0};
    assign is_op   = (opcode == core_pkg::OPC_OP);

    assign rs1_addr_o  = entry_i.instr[19:15];
    assign rs2_addr_o  = entry_i.instr[24:20];
    assign rf.rs1_addr = rs1_addr_o;
    assign rf.rs2_addr = rs2_addr_o;

    // shared by OP and OP-IMM, only OP has SUB.
    always_comb begin
        case (funct3)
            3'b000:  alu_sel = (is_op && alt_bit) ? core_pkg::SUB : core_pkg::ADD;
            3'b001:  alu_sel = core_pkg::SLL;
            3'b010:  alu_sel = core_pkg::SLT;
            3'b011:  alu_sel = core_pkg::SLTU;
            3'b100:  alu_sel = core_pkg::XOR;
            3'b101:  alu_sel = alt_bit ? core_pkg::SRA : core_pkg::SRL;
            3'b110:  alu_sel = core_pkg::OR;
            default: alu_sel = core_pkg::AND;
        endcase
    end

    always_comb begin
        dec_o       = '0;
        dec_o.valid = entry_i.valid;
        dec_o.pc    = entry_i.pc;
        dec_o.rd    = rd;
        rs1_used_o  = 1'b0;
        rs2_used_o  = 1'b0;
        case (opcode)
            core_pkg::OPC_OP: begin
                dec_o.op1    = rf.rs1_data;
                dec_o.op2    = rf.rs2_data;
                dec_o.alu_op = alu_sel;
                dec_o.rd_we  = 1'b1;
                rs1_used_o   = 1'b1;
                rs2_used_o   = 1'b1;
            end
            core_pkg::OPC_OP_IMM: begin
                dec_o.op1    = rf.rs1_data;
                dec_o.op2    = imm_i; // shamt sits in the low bits.
                dec_o.alu_op = alu_sel;
                dec_o.rd_we  = 1'b1;
                rs1_used_o   = 1'b1;
            end
            core_pkg::OPC_LUI: begin
                dec_o.op2    = imm_u;
                dec_o.alu_op = core_pkg::PASS_B;
                dec_o.rd_we  = 1'b1;
            end
            default: begin
                dec_o.rd_we = 1'b0; // passes through, writes nothing.
            end
        endcase
    end

endmodule

// ==== src/pipe_ctrl.sv ====
module pipe_ctrl (
    input  core_pkg::if_id_t    id_entry_i,
    input  core_pkg::reg_addr_t rs1_addr_i,
    input  core_pkg::reg_addr_t rs2_addr_i,
    input  logic                rs1_used_i,
    input  logic                rs2_used_i,
    input  core_pkg::id_ex_t    ex_entry_i,
    input  logic                hold_i,
    output core_pkg::stall_t    stall_o
);

    logic ex_writes;
    logic rs1_hit;
    logic rs2_hit;
    logic hazard;

    // only execute can hold a pending write, ex_wb writes through.
    assign ex_writes = ex_entry_i.valid && ex_entry_i.rd_we && (ex_entry_i.rd != '0);
    assign rs1_hit   = rs1_used_i && (rs1_addr_i == ex_entry_i.rd);
    assign rs2_hit   = rs2_used_i && (rs2_addr_i == ex_entry_i.rd);
    assign hazard    = id_entry_i.valid && ex_writes && (rs1_hit || rs2_hit);

    always_comb begin
        stall_o = '0;
        if (hold_i) begin
            stall_o = '1; // freeze everything.
        end else if (hazard) begin
            stall_o[core_pkg::STALL_ACCEPT] = 1'b1;
            stall_o[core_pkg::STALL_IF_ID]  = 1'b1;
            stall_o[core_pkg::STALL_ID_EX]  = 1'b1; // bubble into execute.
        end
    end

endmodule

// ==== src/pipe_reg.sv ====
module pipe_reg #(
    parameter type payload_t = core_pkg::if_id_t,
    parameter int  STAGE     = 1
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  core_pkg::stall_t stall_i,
    input  payload_t         d_i,
    output payload_t         q_o
);

    logic load;
    logic clr;

    // stage stalled but the next one moves on, so leave a bubble.
    assign load = !stall_i[STAGE];
    assign clr  = stall_i[STAGE] && !stall_i[STAGE+1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0;
        end else if (load) begin
            q_o <= d_i;
        end else if (clr) begin
            q_o <= '0; // bubble.
        end
    end

endmodule

// ==== src/regfile.sv ====
module regfile (
    input  logic                clk,
    input  logic                rst_n_i,
    rf_read_if.rf               rd,
    input  logic                we_i,
    input  core_pkg::reg_addr_t waddr_i,
    input  core_pkg::xlen_t     wdata_i
);

    core_pkg::xlen_t regs [32];
    logic            wr_en;

    assign wr_en = we_i && (waddr_i != '0); // x0 stays zero.

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through so decode sees a result leaving this cycle.
    always_comb begin
        if (wr_en && (rd.rs1_addr == waddr_i)) begin
            rd.rs1_data = wdata_i;
        end else begin
            rd.rs1_data = regs[rd.rs1_addr];
        end
        if (wr_en && (rd.rs2_addr == waddr_i)) begin
            rd.rs2_data = wdata_i;
        end else begin
            rd.rs2_data = regs[rd.rs2_addr];
        end
    end

endmodule

// ==== src/rf_read_if.sv ====
interface rf_read_if;

    core_pkg::reg_addr_t rs1_addr;
    core_pkg::reg_addr_t rs2_addr;
    core_pkg::xlen_t     rs1_data;
    core_pkg::xlen_t     rs2_data;

    modport dec (
        output rs1_addr,
        output rs2_addr,
        input  rs1_data,
        input  rs2_data
    );

    modport rf (
        input  rs1_addr,
        input  rs2_addr,
        output rs1_data,
        output rs2_data
    );

endinterface
